// File: src/regctl_config.svh
`ifndef REGCTL_CONFIG_SVH
`define REGCTL_CONFIG_SVH

// Geometry of the register file
`define REGCTL_N_CONTEXT   2
`define REGCTL_N_IO_REGS   4
`define REGCTL_DATA_W      32
`define REGCTL_ADDR_W      8
`define REGCTL_BE_W        4   // One enable per data byte
`define REGCTL_IDX_W       5   // Register index in addr[4:0]
`define REGCTL_CTX_W       1   // Context in addr[6:5], low bits used
`define REGCTL_IO_IDX_W    2
`define REGCTL_ID_W        8   // Offload and running job IDs

// Mandatory register indices
`define REGCTL_IDX_TRIGGER     0
`define REGCTL_IDX_ACQUIRE     1
`define REGCTL_IDX_FINISHED    2
`define REGCTL_IDX_STATUS      3
`define REGCTL_IDX_RUNNING_JOB 4
`define REGCTL_IDX_SOFT_CLEAR  5
`define REGCTL_IO_BASE         8

// Special read answers
`define REGCTL_RESP_OFFLOADING 32'hFFFF_FFFE
`define REGCTL_RESP_ALL_BUSY   32'hFFFF_FFFF
`define REGCTL_UNKNOWN         32'hDEAD_BEEF

`endif

// File: src/regctl_pkg.sv
`default_nettype none

`include "regctl_config.svh"

package regctl_pkg;

  // One word-addressed bus request, wen high means write
  typedef struct packed {
    logic                       valid;
    logic                       wen;
    logic [`REGCTL_ADDR_W-1:0]  addr;
    logic [`REGCTL_DATA_W-1:0]  wdata;
    logic [`REGCTL_BE_W-1:0]    be;
  } reg_req_t;

  // Response, one cycle after the request
  typedef struct packed {
    logic                       valid;
    logic [`REGCTL_DATA_W-1:0]  rdata;
  } reg_rsp_t;

  typedef logic [`REGCTL_CTX_W-1:0] ctx_t;

  // Parameters handed to the engine for the running job
  typedef logic [`REGCTL_N_IO_REGS-1:0][`REGCTL_DATA_W-1:0] job_params_t;

  // Access kind seen by the job tracker
  typedef enum logic [3:0] {
    ACC_NONE,
    ACC_TRIGGER,
    ACC_ACQUIRE,
    ACC_FINISHED,
    ACC_STATUS,
    ACC_RUNNING_JOB,
    ACC_SOFT_CLEAR,
    ACC_IO,
    ACC_UNKNOWN
  } access_e;

  // Source of the read word one cycle later
  typedef enum logic [1:0] {
    SEL_TRACKER,
    SEL_STORE,
    SEL_UNKNOWN
  } rsp_sel_e;

endpackage

`default_nettype wire

// File: src/reg_access_decode.sv
`default_nettype none
`timescale 1ns/1ps

`include "regctl_config.svh"

module reg_access_decode
  import regctl_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  reg_req_t                    req_i,
  output access_e                     access_o,
  output ctx_t                        ctx_o,
  output logic                        io_we_o,
  output logic [`REGCTL_IO_IDX_W-1:0] io_idx_o,
  input  logic [`REGCTL_DATA_W-1:0]   tracker_rdata_i,
  input  logic [`REGCTL_DATA_W-1:0]   store_rdata_i,
  output reg_rsp_t                    rsp_o
);

  localparam int unsigned IdxW   = `REGCTL_IDX_W;
  localparam int unsigned IoBase = `REGCTL_IO_BASE;
  localparam int unsigned IoEnd  = `REGCTL_IO_BASE + `REGCTL_N_IO_REGS;

  logic [IdxW-1:0] idx;
  logic [IdxW-1:0] io_off;
  logic            is_io;
  rsp_sel_e        sel_d;
  rsp_sel_e        sel_q;
  logic            valid_q;
  logic            wen_q;

  assign idx    = req_i.addr[IdxW-1:0];
  assign ctx_o  = req_i.addr[IdxW +: `REGCTL_CTX_W];
  assign is_io  = (idx >= IdxW'(IoBase)) && (idx < IdxW'(IoEnd));
  assign io_off = idx - IdxW'(IoBase);

  assign io_idx_o = io_off[`REGCTL_IO_IDX_W-1:0];
  assign io_we_o  = req_i.valid & req_i.wen & is_io;

  // Map index and direction to an access kind and a response source
  always_comb begin
    access_o = ACC_NONE;
    sel_d    = SEL_UNKNOWN;
    if (req_i.valid) begin
      access_o = ACC_UNKNOWN;
      if (is_io) begin
        access_o = ACC_IO;
        sel_d    = SEL_STORE;
      end else begin
        case (idx)
          IdxW'(`REGCTL_IDX_TRIGGER): begin
            if (req_i.wen) access_o = ACC_TRIGGER;
          end
          IdxW'(`REGCTL_IDX_ACQUIRE): begin
            if (!req_i.wen) begin
              access_o = ACC_ACQUIRE;  // Test-and-set on read
              sel_d    = SEL_TRACKER;
            end
          end
          IdxW'(`REGCTL_IDX_FINISHED): begin
            access_o = ACC_FINISHED;   // Any access clears the counter
            sel_d    = SEL_TRACKER;
          end
          IdxW'(`REGCTL_IDX_STATUS): begin
            if (!req_i.wen) begin
              access_o = ACC_STATUS;
              sel_d    = SEL_TRACKER;
            end
          end
          IdxW'(`REGCTL_IDX_RUNNING_JOB): begin
            if (!req_i.wen) begin
              access_o = ACC_RUNNING_JOB;
              sel_d    = SEL_TRACKER;
            end
          end
          IdxW'(`REGCTL_IDX_SOFT_CLEAR): begin
            if (req_i.wen) access_o = ACC_SOFT_CLEAR;
          end
          default: access_o = ACC_UNKNOWN;
        endcase
      end
    end
  end

  // Line the select up with the registered read words
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      wen_q   <= 1'b0;
      sel_q   <= SEL_UNKNOWN;
    end else begin
      valid_q <= req_i.valid;
      wen_q   <= req_i.wen;
      sel_q   <= sel_d;
    end
  end

  always_comb begin
    rsp_o.valid = valid_q;
    rsp_o.rdata = '0;             // Writes answer with zero
    if (valid_q && !wen_q) begin
      case (sel_q)
        SEL_TRACKER: rsp_o.rdata = tracker_rdata_i;
        SEL_STORE:   rsp_o.rdata = store_rdata_i;
        default:     rsp_o.rdata = `REGCTL_UNKNOWN;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/job_context_tracker.sv
`default_nettype none
`timescale 1ns/1ps

`include "regctl_config.svh"

module job_context_tracker
  import regctl_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  access_e                   access_i,
  input  logic [`REGCTL_DATA_W-1:0] wdata_i,
  input  logic                      done_i,
  output logic [`REGCTL_DATA_W-1:0] rdata_o,
  output logic                      start_o,
  output logic                      busy_o,
  output ctx_t                      running_ctx_o
);

  localparam int unsigned NCtx  = `REGCTL_N_CONTEXT;
  localparam int unsigned CntW  = $clog2(NCtx + 1);
  localparam int unsigned IdW   = `REGCTL_ID_W;
  localparam int unsigned DataW = `REGCTL_DATA_W;

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e               state_q;
  logic [IdW-1:0]       offload_id_q;
  logic [IdW-1:0]       running_id_q;
  logic                 critical_q;     // A core holds the reservation
  ctx_t                 ptr_ctx_q;      // Next context to be queued
  ctx_t                 run_ctx_q;      // Context the engine works on
  logic [CntW-1:0]      queued_q;
  logic [NCtx-1:0][7:0] status_q;
  logic [1:0]           finished_q;
  logic                 done_q;
  logic [DataW-1:0]     rdata_q;
  logic [DataW-1:0]     status_word;
  logic                 clear;
  logic                 all_busy;
  logic                 acquire_ok;
  logic                 trigger;
  logic                 job_done;
  logic                 launch;

  function automatic ctx_t next_ctx(input ctx_t c);
    next_ctx = (c == ctx_t'(NCtx - 1)) ? '0 : c + 1'b1;
  endfunction

  assign clear      = clear_i | (access_i == ACC_SOFT_CLEAR);
  assign all_busy   = (queued_q == CntW'(NCtx));
  assign acquire_ok = (access_i == ACC_ACQUIRE) && !critical_q && !all_busy;
  // Only a zero written to TRIGGER queues the job, other values are reserved
  assign trigger    = (access_i == ACC_TRIGGER) && critical_q && (wdata_i == '0);
  assign job_done   = done_i && (state_q == ST_BUSY);
  assign launch     = (state_q == ST_IDLE) && (queued_q != '0);

  // Engine FSM with the start pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      start_o <= 1'b0;
    end else if (clear) begin
      state_q <= ST_IDLE;
      start_o <= 1'b0;
    end else begin
      start_o <= launch;
      case (state_q)
        ST_IDLE: if (launch) state_q <= ST_BUSY;
        ST_BUSY: if (job_done) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Job IDs, reservation and context bookkeeping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q <= '0;
      running_id_q <= '0;
      critical_q   <= 1'b0;
      ptr_ctx_q    <= '0;
      run_ctx_q    <= '0;
      queued_q     <= '0;
      status_q     <= '0;
      finished_q   <= '0;
      done_q       <= 1'b0;
    end else if (clear) begin
      offload_id_q <= '0;
      running_id_q <= '0;
      critical_q   <= 1'b0;
      ptr_ctx_q    <= '0;
      run_ctx_q    <= '0;
      queued_q     <= '0;
      status_q     <= '0;
      finished_q   <= '0;
      done_q       <= 1'b0;
    end else begin
      done_q <= job_done;
      if (acquire_ok) offload_id_q <= offload_id_q + 1'b1;
      if (done_q) running_id_q <= running_id_q + 1'b1;  // Lags done by a cycle

      if (acquire_ok) critical_q <= 1'b1;
      else if (trigger) critical_q <= 1'b0;

      if (trigger) ptr_ctx_q <= next_ctx(ptr_ctx_q);
      if (job_done) run_ctx_q <= next_ctx(run_ctx_q);

      if (trigger && !job_done) queued_q <= queued_q + 1'b1;
      else if (job_done && !trigger) queued_q <= queued_q - 1'b1;

      if (job_done) status_q[run_ctx_q] <= 8'h00;
      if (trigger) status_q[ptr_ctx_q] <= 8'h01;

      // Completion counter saturates at 2
      if (access_i == ACC_FINISHED) finished_q <= '0;
      else if (job_done && (finished_q < 2'd2)) finished_q <= finished_q + 1'b1;
    end
  end

  always_comb begin
    status_word = '0;
    status_word[NCtx*8-1:0] = status_q;  // One byte per context
  end

  always_ff @(posedge clk_i) begin
    case (access_i)
      ACC_ACQUIRE: begin
        if (critical_q) rdata_q <= `REGCTL_RESP_OFFLOADING;
        else if (all_busy) rdata_q <= `REGCTL_RESP_ALL_BUSY;
        else rdata_q <= DataW'(offload_id_q);
      end
      ACC_STATUS:      rdata_q <= status_word;
      ACC_FINISHED:    rdata_q <= DataW'(finished_q);
      ACC_RUNNING_JOB: rdata_q <= DataW'(running_id_q);
      default:         rdata_q <= '0;
    endcase
  end

  assign rdata_o       = rdata_q;
  assign busy_o        = (state_q == ST_BUSY);
  assign running_ctx_o = run_ctx_q;

endmodule

`default_nettype wire

// File: src/context_param_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "regctl_config.svh"

module context_param_store
  import regctl_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        we_i,
  input  ctx_t                        ctx_i,
  input  logic [`REGCTL_IO_IDX_W-1:0] idx_i,
  input  logic [`REGCTL_BE_W-1:0]     be_i,
  input  logic [`REGCTL_DATA_W-1:0]   wdata_i,
  input  ctx_t                        running_ctx_i,
  output logic [`REGCTL_DATA_W-1:0]   rdata_o,
  output job_params_t                 params_o
);

  localparam int unsigned BeW = `REGCTL_BE_W;

  // IO registers, one parameter set per context
  job_params_t               mem_q [`REGCTL_N_CONTEXT];
  logic [`REGCTL_DATA_W-1:0] rdata_q;

  // Byte-enable write, untouched bytes keep their value
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < BeW; b++) begin
        if (be_i[b]) begin
          mem_q[ctx_i][idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= mem_q[ctx_i][idx_i];  // Decoder picks it only for IO reads
    end
  end

  assign rdata_o  = rdata_q;
  assign params_o = mem_q[running_ctx_i];  // Follows the running context

endmodule

`default_nettype wire

// File: src/hwpe_regfile_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "regctl_config.svh"

module hwpe_regfile_top
  import regctl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        done_i,
  output logic        start_o,
  output logic        busy_o,
  output job_params_t job_params_o
);

  access_e                     access;
  ctx_t                        req_ctx;
  ctx_t                        running_ctx;
  logic                        io_we;
  logic [`REGCTL_IO_IDX_W-1:0] io_idx;
  logic [`REGCTL_DATA_W-1:0]   tracker_rdata;
  logic [`REGCTL_DATA_W-1:0]   store_rdata;

  reg_access_decode u_decode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (reg_req_i),
    .access_o        (access),
    .ctx_o           (req_ctx),
    .io_we_o         (io_we),
    .io_idx_o        (io_idx),
    .tracker_rdata_i (tracker_rdata),
    .store_rdata_i   (store_rdata),
    .rsp_o           (reg_rsp_o)
  );

  job_context_tracker u_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .access_i      (access),
    .wdata_i       (reg_req_i.wdata),
    .done_i        (done_i),
    .rdata_o       (tracker_rdata),
    .start_o       (start_o),
    .busy_o        (busy_o),
    .running_ctx_o (running_ctx)
  );

  // Parameter array keeps its content across clears
  context_param_store u_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .we_i          (io_we),
    .ctx_i         (req_ctx),
    .idx_i         (io_idx),
    .be_i          (reg_req_i.be),
    .wdata_i       (reg_req_i.wdata),
    .running_ctx_i (running_ctx),
    .rdata_o       (store_rdata),
    .params_o      (job_params_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_hwpe_regfile.sv
`default_nettype none
`timescale 1ns/1ps

`include "regctl_config.svh"

module tb_hwpe_regfile
  import regctl_pkg::*;
();

  localparam int unsigned TimeoutCycles = 50;

  logic        clk_i;
  logic        rst_ni;
  logic        clear;
  logic        done;
  reg_req_t    req;
  reg_rsp_t    rsp;
  logic        start;
  logic        busy;
  job_params_t job_params;

  logic [31:0] exp_params [`REGCTL_N_CONTEXT][`REGCTL_N_IO_REGS];  // Last value written
  job_params_t started_params [$];  // Parameters seen with each start pulse
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          test_errors;
  string       cur_test;

  hwpe_regfile_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .reg_req_i    (req),
    .reg_rsp_o    (rsp),
    .done_i       (done),
    .start_o      (start),
    .busy_o       (busy),
    .job_params_o (job_params)
  );

  always #4 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (rst_ni && start) started_params.push_back(job_params);
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) result[b*8 +: 8] = new_word[b*8 +: 8];  // Enabled bytes only
    end
    return result;
  endfunction

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      n_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("%s: timed out waiting for %s", cur_test, what);
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s finished with %0d errors", cur_test, n_errors - test_errors);
  endtask

  // One request, then wait for its response
  task automatic bus_access(input logic wen, input int ctx, input int idx,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk_i);
    req.valid <= 1'b1;
    req.wen   <= wen;
    req.addr  <= {1'b0, ctx[1:0], idx[4:0]};
    req.wdata <= wdata;
    req.be    <= be;
    @(posedge clk_i);
    req.valid <= 1'b0;
    @(negedge clk_i);
    while (!rsp.valid && waited < TimeoutCycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (!rsp.valid) begin
      report_timeout("a bus response");
    end else begin
      check_word("response delay in cycles", 32'h0, 32'(waited));  // Answer one cycle later
      rdata = rsp.rdata;
      if (wen) check_word("write response data", 32'h0, rsp.rdata);
    end
  endtask

  task automatic reg_write(input int ctx, input int idx, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] ignored;
    bus_access(1'b1, ctx, idx, wdata, be, ignored);
  endtask

  task automatic read_expect(input string what, input int ctx, input int idx,
                             input logic [31:0] exp);
    logic [31:0] rdata;
    bus_access(1'b0, ctx, idx, 32'h0, 4'h0, rdata);
    check_word(what, exp, rdata);
  endtask

  // The n-th start pulse must carry the parameters of context ctx
  task automatic expect_start(input int n, input int ctx);
    int waited;
    waited = 0;
    while (started_params.size() < n && waited < TimeoutCycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (started_params.size() < n) begin
      report_timeout("a start pulse");
    end else begin
      for (int i = 0; i < `REGCTL_N_IO_REGS; i++) begin
        check_word($sformatf("param %0d at start %0d", i, n), exp_params[ctx][i],
                   started_params[n-1][i]);
      end
    end
  endtask

  task automatic finish_job();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!busy && waited < TimeoutCycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (!busy) begin
      report_timeout("the engine to become busy");
    end else begin
      @(posedge clk_i);
      done <= 1'b1;
      @(posedge clk_i);
      done <= 1'b0;
    end
  endtask

  task automatic check_cleared(input string label);
    read_expect({"STATUS ", label}, 0, `REGCTL_IDX_STATUS, 32'h0);
    read_expect({"RUNNING_JOB ", label}, 0, `REGCTL_IDX_RUNNING_JOB, 32'h0);
    read_expect({"FINISHED ", label}, 0, `REGCTL_IDX_FINISHED, 32'h0);
    check_word({"busy ", label}, 32'h0, 32'(busy));
    read_expect({"ACQUIRE ", label}, 0, `REGCTL_IDX_ACQUIRE, 32'h0);
  endtask

  task automatic test_reset();
    begin_test("reset");
    @(negedge clk_i);
    check_word("start after reset", 32'h0, 32'(start));
    check_word("busy after reset", 32'h0, 32'(busy));
    check_word("response valid after reset", 32'h0, 32'(rsp.valid));
    read_expect("STATUS", 0, `REGCTL_IDX_STATUS, 32'h0);
    read_expect("FINISHED", 0, `REGCTL_IDX_FINISHED, 32'h0);
    read_expect("RUNNING_JOB", 0, `REGCTL_IDX_RUNNING_JOB, 32'h0);
    read_expect("unmapped index", 0, `REGCTL_IDX_SOFT_CLEAR + 1, `REGCTL_UNKNOWN);
    read_expect("first ACQUIRE", 0, `REGCTL_IDX_ACQUIRE, 32'h0);
    end_test();
  endtask

  task automatic test_io_regs();
    logic [31:0] data;
    begin_test("io_regs");
    for (int c = 0; c < `REGCTL_N_CONTEXT; c++) begin
      for (int i = 0; i < `REGCTL_N_IO_REGS; i++) begin
        data = $urandom();
        exp_params[c][i] = data;
        reg_write(c, `REGCTL_IO_BASE + i, data, 4'hF);
      end
    end
    // Bytes 0 and 2 only
    data = $urandom();
    reg_write(0, `REGCTL_IO_BASE + 1, data, 4'b0101);
    exp_params[0][1] = merge_bytes(exp_params[0][1], data, 4'b0101);
    for (int c = 0; c < `REGCTL_N_CONTEXT; c++) begin
      for (int i = 0; i < `REGCTL_N_IO_REGS; i++) begin
        read_expect($sformatf("IO ctx %0d reg %0d", c, i), c, `REGCTL_IO_BASE + i,
                    exp_params[c][i]);
      end
    end
    end_test();
  endtask

  task automatic test_reservation();
    begin_test("reservation");
    read_expect("second ACQUIRE", 0, `REGCTL_IDX_ACQUIRE, `REGCTL_RESP_OFFLOADING);
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    read_expect("ACQUIRE after TRIGGER", 0, `REGCTL_IDX_ACQUIRE, 32'h1);
    end_test();
  endtask

  task automatic test_all_busy();
    begin_test("all_busy");
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    read_expect("STATUS", 0, `REGCTL_IDX_STATUS, 32'h0000_0101);
    read_expect("ACQUIRE", 0, `REGCTL_IDX_ACQUIRE, `REGCTL_RESP_ALL_BUSY);
    end_test();
  endtask

  task automatic test_jobs();
    begin_test("jobs");
    expect_start(1, 0);
    finish_job();
    read_expect("STATUS after done 1", 0, `REGCTL_IDX_STATUS, 32'h0000_0100);
    read_expect("RUNNING_JOB after done 1", 0, `REGCTL_IDX_RUNNING_JOB, 32'h1);
    expect_start(2, 1);
    finish_job();
    read_expect("STATUS after done 2", 0, `REGCTL_IDX_STATUS, 32'h0);
    read_expect("RUNNING_JOB after done 2", 0, `REGCTL_IDX_RUNNING_JOB, 32'h2);
    read_expect("third ACQUIRE", 0, `REGCTL_IDX_ACQUIRE, 32'h2);
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    expect_start(3, 0);
    finish_job();
    read_expect("RUNNING_JOB after done 3", 0, `REGCTL_IDX_RUNNING_JOB, 32'h3);
    read_expect("FINISHED saturated", 0, `REGCTL_IDX_FINISHED, 32'h2);
    reg_write(0, `REGCTL_IDX_FINISHED, 32'h0, 4'hF);
    read_expect("FINISHED after write", 0, `REGCTL_IDX_FINISHED, 32'h0);
    end_test();
  endtask

  task automatic test_clear();
    begin_test("clear");
    read_expect("ACQUIRE before soft clear", 0, `REGCTL_IDX_ACQUIRE, 32'h3);
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    expect_start(4, 1);
    // Leave one job done and one running so the clear has state to undo
    read_expect("next ACQUIRE before soft clear", 0, `REGCTL_IDX_ACQUIRE, 32'h4);
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    finish_job();
    expect_start(5, 0);
    reg_write(0, `REGCTL_IDX_SOFT_CLEAR, 32'h0, 4'hF);
    check_cleared("after soft clear");
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    expect_start(6, 0);
    finish_job();
    read_expect("RUNNING_JOB before clear pulse", 0, `REGCTL_IDX_RUNNING_JOB, 32'h1);
    read_expect("ACQUIRE before clear pulse", 0, `REGCTL_IDX_ACQUIRE, 32'h1);
    reg_write(0, `REGCTL_IDX_TRIGGER, 32'h0, 4'hF);
    read_expect("STATUS before clear pulse", 0, `REGCTL_IDX_STATUS, 32'h0000_0100);
    @(posedge clk_i);
    clear <= 1'b1;
    @(posedge clk_i);
    clear <= 1'b0;
    check_cleared("after clear pulse");
    end_test();
  endtask

  initial begin
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    clear    = 1'b0;
    done     = 1'b0;
    req      = '0;
    n_checks = 0;
    n_errors = 0;
    n_tests  = 0;
    void'($urandom(32'hbf768fa5));
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset();
    test_io_regs();
    test_reservation();
    test_all_busy();
    test_jobs();
    test_clear();

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hwpe_regfile.f
+incdir+src
src/regctl_pkg.sv
src/reg_access_decode.sv
src/job_context_tracker.sv
src/context_param_store.sv
src/hwpe_regfile_top.sv
verif/tb_hwpe_regfile.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_hwpe_regfile -f hwpe_regfile.f \
  -o tb_hwpe_regfile > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_hwpe_regfile > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0
